//--- Bender.yml
package:
  name: wb_interconnect

sources:
  - design/ic_pkg.sv
  - design/wb_if.sv
  - design/wb_arbiter.sv
  - design/wb_target_decode.sv
  - design/iram_target.sv
  - design/gpio_target.sv
  - design/interconnect_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_top.sv

//--- design/gpio_target.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_target (
    input  logic                      core_clock,
    input  logic                      core_reset,
    wb_if.slave                       bus,
    input  logic [ic_pkg::GPIO_N-1:0] gpio_in_i,
    output logic [ic_pkg::GPIO_N-1:0] gpio_out_o,
    output logic [ic_pkg::GPIO_N-1:0] gpio_oeb_o
);
    import ic_pkg::*;

    logic [GPIO_N-1:0]   out_q;
    logic [GPIO_N-1:0]   dir_q;
    logic [GPIO_N-1:0]   sync1_q;
    logic [GPIO_N-1:0]   sync2_q;
    logic [GPIO_N-1:0]   rd_val;
    logic [WB_DAT_W-1:0] dat_q;
    logic                ack_q;
    logic                take;

    assign take = bus.cyc & bus.stb & ~ack_q;

    // Two-flop synchronizer on the pins
    always_ff @(posedge core_clock) begin
        sync1_q <= gpio_in_i;
        sync2_q <= sync1_q;
    end

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            out_q <= '0;
            dir_q <= '1;
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
            if (take && bus.we) begin
                for (int b = 0; b < GPIO_N / 8; b++) begin
                    if (bus.sel[b] && bus.adr[1:0] == GPIO_OUT_OFS) begin
                        out_q[b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                    end
                    if (bus.sel[b] && bus.adr[1:0] == GPIO_DIR_OFS) begin
                        dir_q[b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        case (bus.adr[1:0])
            GPIO_OUT_OFS: rd_val = out_q;
            GPIO_DIR_OFS: rd_val = dir_q;
            GPIO_IN_OFS:  rd_val = sync2_q;
            default:      rd_val = '0;
        endcase
    end

    always_ff @(posedge core_clock) begin
        if (take) begin
            dat_q <= {{(WB_DAT_W - GPIO_N){1'b0}}, rd_val};
        end
    end

    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;
    assign bus.dat_r = dat_q;

    assign gpio_out_o = out_q;
    // Direction bit high means input
    assign gpio_oeb_o = dir_q;

endmodule

`default_nettype wire

//--- design/ic_pkg.sv
`default_nettype none

package ic_pkg;

    // Bus widths
    localparam int WB_ADR_W = 24;
    localparam int WB_DAT_W = 16;
    localparam int WB_SEL_W = 2;

    // Internal RAM is word addressed
    localparam int IRAM_DEPTH = 512;
    localparam int IRAM_AW    = $clog2(IRAM_DEPTH);

    // Both embed RAM windows alias the same words
    localparam logic [WB_ADR_W-1:0] NE_IRAM_BASE = 24'h7ffe00;
    localparam logic [WB_ADR_W-1:0] E_PROG_BASE  = 24'h800000;
    localparam logic [WB_ADR_W-1:0] E_MEM_BASE   = 24'h100000;

    // GPIO block has three registers from the base
    localparam logic [WB_ADR_W-1:0] GPIO_BASE    = 24'h001010;
    localparam logic [1:0]          GPIO_OUT_OFS = 2'd0;
    localparam logic [1:0]          GPIO_DIR_OFS = 2'd1;
    localparam logic [1:0]          GPIO_IN_OFS  = 2'd2;
    localparam int                  GPIO_N       = 8;

endpackage

`default_nettype wire

//--- design/interconnect_top.sv
`timescale 1ns/10ps
`default_nettype none

module interconnect_top (
    input  logic                        core_clock,
    input  logic                        core_reset,
    input  logic                        embed_mode_i,

    // Host master standing in for the external bridge
    input  logic                        host_cyc_i,
    input  logic                        host_stb_i,
    input  logic                        host_we_i,
    input  logic [ic_pkg::WB_ADR_W-1:0] host_adr_i,
    input  logic [ic_pkg::WB_SEL_W-1:0] host_sel_i,
    input  logic [ic_pkg::WB_DAT_W-1:0] host_dat_i,
    output logic [ic_pkg::WB_DAT_W-1:0] host_dat_o,
    output logic                        host_ack_o,
    output logic                        host_err_o,

    // Inner master of the core
    input  logic                        inner_cyc_i,
    input  logic                        inner_stb_i,
    input  logic                        inner_we_i,
    input  logic [ic_pkg::WB_ADR_W-1:0] inner_adr_i,
    input  logic [ic_pkg::WB_SEL_W-1:0] inner_sel_i,
    input  logic [ic_pkg::WB_DAT_W-1:0] inner_dat_i,
    output logic [ic_pkg::WB_DAT_W-1:0] inner_dat_o,
    output logic                        inner_ack_o,
    output logic                        inner_err_o,

    input  logic [ic_pkg::GPIO_N-1:0]   gpio_in_i,
    output logic [ic_pkg::GPIO_N-1:0]   gpio_out_o,
    output logic [ic_pkg::GPIO_N-1:0]   gpio_oeb_o
);

    wb_if host_bus ();
    wb_if inner_bus ();
    wb_if arb_bus ();
    wb_if iram_bus ();
    wb_if gpio_bus ();

    assign host_bus.cyc   = host_cyc_i;
    assign host_bus.stb   = host_stb_i;
    assign host_bus.we    = host_we_i;
    assign host_bus.adr   = host_adr_i;
    assign host_bus.sel   = host_sel_i;
    assign host_bus.dat_w = host_dat_i;
    assign host_dat_o     = host_bus.dat_r;
    assign host_ack_o     = host_bus.ack;
    assign host_err_o     = host_bus.err;

    assign inner_bus.cyc   = inner_cyc_i;
    assign inner_bus.stb   = inner_stb_i;
    assign inner_bus.we    = inner_we_i;
    assign inner_bus.adr   = inner_adr_i;
    assign inner_bus.sel   = inner_sel_i;
    assign inner_bus.dat_w = inner_dat_i;
    assign inner_dat_o     = inner_bus.dat_r;
    assign inner_ack_o     = inner_bus.ack;
    assign inner_err_o     = inner_bus.err;

    wb_arbiter u_arbiter (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .m0         (host_bus),
        .m1         (inner_bus),
        .bus        (arb_bus)
    );

    wb_target_decode u_decode (
        .core_clock   (core_clock),
        .core_reset   (core_reset),
        .embed_mode_i (embed_mode_i),
        .bus          (arb_bus),
        .iram         (iram_bus),
        .gpio         (gpio_bus)
    );

    iram_target u_iram (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .bus        (iram_bus)
    );

    gpio_target u_gpio (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .bus        (gpio_bus),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oeb_o (gpio_oeb_o)
    );

endmodule

`default_nettype wire

//--- design/iram_target.sv
`timescale 1ns/10ps
`default_nettype none

module iram_target (
    input  logic core_clock,
    input  logic core_reset,
    wb_if.slave  bus
);
    import ic_pkg::*;

    logic [WB_DAT_W-1:0] mem [IRAM_DEPTH];
    logic [IRAM_AW-1:0]  idx;
    logic [WB_DAT_W-1:0] dat_q;
    logic                ack_q;
    logic                take;

    assign idx  = bus.adr[IRAM_AW-1:0];
    // Held strobe in the ack cycle is not a new request
    assign take = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    always_ff @(posedge core_clock) begin
        if (take) begin
            if (bus.we) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
                    end
                end
            end
            dat_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.err   = 1'b0;
    assign bus.dat_r = dat_q;

    a_ack_single: assert property (
        @(posedge core_clock) disable iff (core_reset)
        ack_q |=> !ack_q
    ) else $error("iram_target: ack held for two cycles");

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  logic core_clock,
    input  logic core_reset,
    wb_if.slave  m0,
    wb_if.slave  m1,
    wb_if.master bus
);

    // One-hot grant is zero when the bus is idle
    logic [1:0] grant_q;
    logic       last_q;
    logic       pick;
    logic       m0_pass;
    logic       m1_pass;

    // With both requesting the master not served last wins
    always_comb begin
        if (m0.cyc && m1.cyc) begin
            pick = ~last_q;
        end else begin
            pick = m1.cyc;
        end
    end

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            grant_q <= 2'b00;
            last_q  <= 1'b0;
        end else if (grant_q == 2'b00) begin
            if (m0.cyc || m1.cyc) begin
                grant_q <= pick ? 2'b10 : 2'b01;
                last_q  <= pick;
            end
        end else if (!bus.cyc) begin
            // Owner dropped cyc
            grant_q <= 2'b00;
        end
    end

    assign m0_pass = grant_q[0] & m0.cyc;
    assign m1_pass = grant_q[1] & m1.cyc;

    assign bus.cyc   = m0_pass | m1_pass;
    assign bus.stb   = (grant_q[0] & m0.stb) | (grant_q[1] & m1.stb);
    assign bus.we    = grant_q[1] ? m1.we    : m0.we;
    assign bus.adr   = grant_q[1] ? m1.adr   : m0.adr;
    assign bus.sel   = grant_q[1] ? m1.sel   : m0.sel;
    assign bus.dat_w = grant_q[1] ? m1.dat_w : m0.dat_w;

    // Responses go back to the owner only
    assign m0.ack   = grant_q[0] & bus.ack;
    assign m0.err   = grant_q[0] & bus.err;
    assign m0.dat_r = grant_q[0] ? bus.dat_r : '0;
    assign m1.ack   = grant_q[1] & bus.ack;
    assign m1.err   = grant_q[1] & bus.err;
    assign m1.dat_r = grant_q[1] ? bus.dat_r : '0;

    a_one_cyc_owner: assert property (
        @(posedge core_clock) disable iff (core_reset)
        !(m0_pass && m1_pass)
    ) else $error("wb_arbiter: cyc passed from both masters");

endmodule

`default_nettype wire

//--- design/wb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_if;
    import ic_pkg::*;

    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_SEL_W-1:0] sel;
    logic [WB_DAT_W-1:0] dat_w;
    logic [WB_DAT_W-1:0] dat_r;
    logic                ack;
    logic                err;

    modport master (
        output cyc, stb, we, adr, sel, dat_w,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, sel, dat_w,
        output dat_r, ack, err
    );

endinterface

`default_nettype wire

//--- design/wb_target_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_target_decode (
    input  logic core_clock,
    input  logic core_reset,
    input  logic embed_mode_i,
    wb_if.slave  bus,
    wb_if.master iram,
    wb_if.master gpio
);
    import ic_pkg::*;

    logic hit_ne;
    logic hit_prog;
    logic hit_mem;
    logic sel_iram;
    logic sel_gpio;
    logic unmapped;
    logic err_q;

    // RAM windows are aligned to the RAM size, so compare the upper bits
    assign hit_ne   = bus.adr[WB_ADR_W-1:IRAM_AW] == NE_IRAM_BASE[WB_ADR_W-1:IRAM_AW];
    assign hit_prog = bus.adr[WB_ADR_W-1:IRAM_AW] == E_PROG_BASE[WB_ADR_W-1:IRAM_AW];
    assign hit_mem  = bus.adr[WB_ADR_W-1:IRAM_AW] == E_MEM_BASE[WB_ADR_W-1:IRAM_AW];

    assign sel_iram = embed_mode_i ? (hit_prog | hit_mem) : hit_ne;
    assign sel_gpio = (bus.adr[WB_ADR_W-1:2] == GPIO_BASE[WB_ADR_W-1:2])
                      && (bus.adr[1:0] <= GPIO_IN_OFS);
    assign unmapped = !sel_iram && !sel_gpio;

    // Strobe goes only to the selected target
    assign iram.cyc   = bus.cyc;
    assign iram.stb   = bus.cyc & bus.stb & sel_iram;
    assign iram.we    = bus.we;
    assign iram.adr   = bus.adr;
    assign iram.sel   = bus.sel;
    assign iram.dat_w = bus.dat_w;

    assign gpio.cyc   = bus.cyc;
    assign gpio.stb   = bus.cyc & bus.stb & sel_gpio;
    assign gpio.we    = bus.we;
    assign gpio.adr   = bus.adr;
    assign gpio.sel   = bus.sel;
    assign gpio.dat_w = bus.dat_w;

    // One err pulse per strobe to an unmapped address
    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            err_q <= 1'b0;
        end else begin
            err_q <= bus.cyc & bus.stb & unmapped & ~err_q;
        end
    end

    assign bus.ack = (sel_iram & iram.ack) | (sel_gpio & gpio.ack);
    assign bus.err = err_q | (sel_iram & iram.err) | (sel_gpio & gpio.err);

    always_comb begin
        if (sel_gpio) begin
            bus.dat_r = gpio.dat_r;
        end else if (sel_iram) begin
            bus.dat_r = iram.dat_r;
        end else begin
            bus.dat_r = '0;
        end
    end

    a_ack_err_excl: assert property (
        @(posedge core_clock) disable iff (core_reset)
        !(bus.ack && bus.err)
    ) else $error("wb_target_decode: ack and err together");

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
design/ic_pkg.sv
design/wb_if.sv
design/wb_arbiter.sv
design/wb_target_decode.sv
design/iram_target.sv
design/gpio_target.sv
design/interconnect_top.sv
verif/tb_top.sv

//--- verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Target kinds of the address map
localparam int TGT_RAM  = 0;
localparam int TGT_GPIO = 1;
localparam int TGT_NONE = 2;

logic [WB_DAT_W-1:0] ram_model [IRAM_DEPTH];
logic [GPIO_N-1:0]   gpio_out_m = '0;
logic [GPIO_N-1:0]   gpio_dir_m = '1;
logic [GPIO_N-1:0]   gpio_in_m  = '0;

function automatic bit in_window(input logic [WB_ADR_W-1:0] adr,
                                 input logic [WB_ADR_W-1:0] base, input int size);
    return (adr >= base) && (adr < base + size);
endfunction

function automatic int decode_target(input logic [WB_ADR_W-1:0] adr, input logic embed);
    if (in_window(adr, GPIO_BASE, 3)) begin
        return TGT_GPIO;
    end
    if (!embed && in_window(adr, NE_IRAM_BASE, IRAM_DEPTH)) begin
        return TGT_RAM;
    end
    // Both embed windows alias the same words
    if (embed && (in_window(adr, E_PROG_BASE, IRAM_DEPTH)
                  || in_window(adr, E_MEM_BASE, IRAM_DEPTH))) begin
        return TGT_RAM;
    end
    return TGT_NONE;
endfunction

function automatic void model_write(input logic [WB_ADR_W-1:0] adr, input logic embed,
                                    input logic [WB_SEL_W-1:0] sel,
                                    input logic [WB_DAT_W-1:0] wdat);
    int tgt;
    tgt = decode_target(adr, embed);
    if (tgt == TGT_RAM) begin
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                ram_model[adr % IRAM_DEPTH][b*8 +: 8] = wdat[b*8 +: 8];
            end
        end
    end else if (tgt == TGT_GPIO && sel[0]) begin
        if (adr == GPIO_BASE + GPIO_OUT_OFS) begin
            gpio_out_m = wdat[7:0];
        end else if (adr == GPIO_BASE + GPIO_DIR_OFS) begin
            gpio_dir_m = wdat[7:0];
        end
    end
endfunction

function automatic logic [WB_DAT_W-1:0] expected_read(input logic [WB_ADR_W-1:0] adr,
                                                      input logic embed);
    logic [WB_DAT_W-1:0] val;
    val = '0;
    if (decode_target(adr, embed) == TGT_RAM) begin
        val = ram_model[adr % IRAM_DEPTH];
    end else if (adr == GPIO_BASE + GPIO_OUT_OFS) begin
        val[7:0] = gpio_out_m;
    end else if (adr == GPIO_BASE + GPIO_DIR_OFS) begin
        val[7:0] = gpio_dir_m;
    end else if (adr == GPIO_BASE + GPIO_IN_OFS) begin
        val[7:0] = gpio_in_m;
    end
    return val;
endfunction

`endif

//--- verif/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;
    import ic_pkg::*;

    // Roughly 400 transfers at up to 8 cycles each plus margin
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int USED_WORDS     = 64;

    typedef struct packed {
        logic                inner;
        logic                we;
        logic                embed;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_SEL_W-1:0] sel;
        logic [WB_DAT_W-1:0] wdat;
        logic [WB_DAT_W-1:0] rdat;
        logic                ack;
        logic                err;
    } xfer_t;

    logic                core_clock;
    logic                core_reset;
    logic                embed_mode;
    logic                host_cyc;
    logic                host_stb;
    logic                host_we;
    logic [WB_ADR_W-1:0] host_adr;
    logic [WB_SEL_W-1:0] host_sel;
    logic [WB_DAT_W-1:0] host_wdat;
    logic [WB_DAT_W-1:0] host_rdat;
    logic                host_ack;
    logic                host_err;
    logic                inner_cyc;
    logic                inner_stb;
    logic                inner_we;
    logic [WB_ADR_W-1:0] inner_adr;
    logic [WB_SEL_W-1:0] inner_sel;
    logic [WB_DAT_W-1:0] inner_wdat;
    logic [WB_DAT_W-1:0] inner_rdat;
    logic                inner_ack;
    logic                inner_err;
    logic [GPIO_N-1:0]   gpio_in;
    logic [GPIO_N-1:0]   gpio_out;
    logic [GPIO_N-1:0]   gpio_oeb;

    integer seed = 32'hd77e_9e87;
    int     cycles = 0;
    int     host_xfers = 0;
    int     inner_xfers = 0;
    int     host_resps = 0;
    int     inner_resps = 0;
    xfer_t  done_q[$];

    `include "tb_model.svh"

    interconnect_top dut0 (
        .core_clock   (core_clock),
        .core_reset   (core_reset),
        .embed_mode_i (embed_mode),
        .host_cyc_i   (host_cyc),
        .host_stb_i   (host_stb),
        .host_we_i    (host_we),
        .host_adr_i   (host_adr),
        .host_sel_i   (host_sel),
        .host_dat_i   (host_wdat),
        .host_dat_o   (host_rdat),
        .host_ack_o   (host_ack),
        .host_err_o   (host_err),
        .inner_cyc_i  (inner_cyc),
        .inner_stb_i  (inner_stb),
        .inner_we_i   (inner_we),
        .inner_adr_i  (inner_adr),
        .inner_sel_i  (inner_sel),
        .inner_dat_i  (inner_wdat),
        .inner_dat_o  (inner_rdat),
        .inner_ack_o  (inner_ack),
        .inner_err_o  (inner_err),
        .gpio_in_i    (gpio_in),
        .gpio_out_o   (gpio_out),
        .gpio_oeb_o   (gpio_oeb)
    );

    initial begin
        core_clock = 1'b0;
        forever #4 core_clock = ~core_clock;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    always @(posedge core_clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: tests did not finish within %0d cycles", cycles));
        end
    end

    // Count response cycles per master to compare with finished transfers
    always @(negedge core_clock) begin
        if (!core_reset) begin
            if (host_ack || host_err) begin
                host_resps++;
            end
            if (inner_ack || inner_err) begin
                inner_resps++;
            end
        end
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Low and high halves of the RAM hold the words under test
    function automatic int used_word(input int k);
        return (k < USED_WORDS / 2) ? k : IRAM_DEPTH / 2 + k - USED_WORDS / 2;
    endfunction

    task automatic bus_xfer(input logic inner, input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_SEL_W-1:0] sel, input logic [WB_DAT_W-1:0] wdat);
        xfer_t r;
        r.inner = inner;
        r.we    = we;
        r.embed = embed_mode;
        r.adr   = adr;
        r.sel   = sel;
        r.wdat  = wdat;
        @(posedge core_clock);
        #1;
        if (inner) begin
            {inner_cyc, inner_stb, inner_we} = {2'b11, we};
            {inner_adr, inner_sel, inner_wdat} = {adr, sel, wdat};
        end else begin
            {host_cyc, host_stb, host_we} = {2'b11, we};
            {host_adr, host_sel, host_wdat} = {adr, sel, wdat};
        end
        @(negedge core_clock);
        while (inner ? !(inner_ack || inner_err) : !(host_ack || host_err)) begin
            @(negedge core_clock);
        end
        r.ack  = inner ? inner_ack : host_ack;
        r.err  = inner ? inner_err : host_err;
        r.rdat = inner ? inner_rdat : host_rdat;
        @(posedge core_clock);
        #1;
        if (inner) begin
            {inner_cyc, inner_stb} = 2'b00;
        end else begin
            {host_cyc, host_stb} = 2'b00;
        end
        done_q.push_back(r);
    endtask

    task automatic read_all_used(input logic [WB_ADR_W-1:0] base);
        for (int k = 0; k < USED_WORDS; k++) begin
            bus_xfer(k % 2, 1'b0, base + used_word(k), 2'b11, '0);
        end
    endtask

    // Compares each finished transfer with the model in completion order
    initial begin : response_check
        xfer_t               r;
        int                  tgt;
        logic [WB_DAT_W-1:0] exp;
        string               port;
        forever begin
            wait (done_q.size() > 0);
            r = done_q.pop_front();
            port = r.inner ? "inner" : "host";
            tgt = decode_target(r.adr, r.embed);
            assert (r.ack === (tgt != TGT_NONE))
                else report_mismatch({port, "_ack_o"}, tgt != TGT_NONE, r.ack);
            assert (r.err === (tgt == TGT_NONE))
                else report_mismatch({port, "_err_o"}, tgt == TGT_NONE, r.err);
            if (r.we) begin
                model_write(r.adr, r.embed, r.sel, r.wdat);
            end else if (tgt != TGT_NONE) begin
                exp = expected_read(r.adr, r.embed);
                assert (r.rdat === exp) else report_mismatch({port, "_dat_o"}, exp, r.rdat);
            end
            if (r.inner) begin
                inner_xfers++;
            end else begin
                host_xfers++;
            end
        end
    end

    initial begin
        logic [WB_ADR_W-1:0] adr;
        int                  off;
        core_reset = 1'b1;
        embed_mode = 1'b0;
        {host_cyc, host_stb, host_we, host_adr, host_sel, host_wdat} = '0;
        {inner_cyc, inner_stb, inner_we, inner_adr, inner_sel, inner_wdat} = '0;
        gpio_in = '0;
        repeat (3) @(posedge core_clock);
        #1;
        core_reset = 1'b0;
        assert (gpio_out === 8'h00) else report_mismatch("gpio_out_o", 8'h00, gpio_out);
        assert (gpio_oeb === 8'hff) else report_mismatch("gpio_oeb_o", 8'hff, gpio_oeb);

        // Fill the words under test in the default map before partial writes
        for (int k = 0; k < USED_WORDS; k++) begin
            bus_xfer(k >= USED_WORDS / 2, 1'b1, NE_IRAM_BASE + used_word(k), 2'b11, $random(seed));
        end
        for (int n = 0; n < 40; n++) begin
            off = used_word(rand_below(USED_WORDS));
            bus_xfer(rand_below(2), 1'b1, NE_IRAM_BASE + off, rand_below(4), $random(seed));
        end
        read_all_used(NE_IRAM_BASE);

        @(posedge core_clock);
        #1;
        embed_mode = 1'b1;
        for (int n = 0; n < 16; n++) begin
            off = used_word(rand_below(USED_WORDS));
            bus_xfer(1'b0, 1'b1, E_PROG_BASE + off, rand_below(4), $random(seed));
            bus_xfer(1'b1, 1'b0, E_MEM_BASE + off, 2'b11, '0);
        end
        // Default window answers with err in embed mode
        for (int n = 0; n < 4; n++) begin
            off = used_word(rand_below(USED_WORDS));
            bus_xfer(n % 2, 1'b1, NE_IRAM_BASE + off, 2'b11, $random(seed));
            bus_xfer(n % 2, 1'b0, NE_IRAM_BASE + off, 2'b11, '0);
            bus_xfer(n % 2 == 0, 1'b0, E_MEM_BASE + off, 2'b11, '0);
        end
        @(posedge core_clock);
        #1;
        embed_mode = 1'b0;

        for (int n = 0; n < 24; n++) begin
            do begin
                adr = $random(seed);
            end while (decode_target(adr, 1'b0) != TGT_NONE);
            bus_xfer(n % 2, rand_below(2), adr, rand_below(4), $random(seed));
        end
        read_all_used(NE_IRAM_BASE);

        bus_xfer(1'b0, 1'b0, GPIO_BASE + GPIO_OUT_OFS, 2'b11, '0);
        bus_xfer(1'b1, 1'b0, GPIO_BASE + GPIO_DIR_OFS, 2'b11, '0);
        bus_xfer(1'b0, 1'b1, GPIO_BASE + GPIO_OUT_OFS, 2'b01, $random(seed));
        bus_xfer(1'b1, 1'b1, GPIO_BASE + GPIO_DIR_OFS, 2'b01, $random(seed));
        bus_xfer(1'b0, 1'b1, GPIO_BASE + GPIO_IN_OFS, 2'b11, 16'hffff);
        wait (done_q.size() == 0);
        assert (gpio_out === gpio_out_m) else report_mismatch("gpio_out_o", gpio_out_m, gpio_out);
        assert (gpio_oeb === gpio_dir_m) else report_mismatch("gpio_oeb_o", gpio_dir_m, gpio_oeb);
        bus_xfer(1'b1, 1'b0, GPIO_BASE + GPIO_OUT_OFS, 2'b11, '0);
        bus_xfer(1'b0, 1'b0, GPIO_BASE + GPIO_DIR_OFS, 2'b11, '0);
        repeat (2) begin
            @(posedge core_clock);
            #1;
            gpio_in = $random(seed);
            gpio_in_m = gpio_in;
            repeat (4) @(posedge core_clock);
            bus_xfer(1'b1, 1'b0, GPIO_BASE + GPIO_IN_OFS, 2'b11, '0);
        end

        // Both masters at once on separate halves of the RAM
        fork
            for (int n = 0; n < 40; n++) begin
                bus_xfer(1'b0, rand_below(2), NE_IRAM_BASE + used_word(rand_below(32)),
                         rand_below(4), $random(seed));
            end
            for (int n = 0; n < 40; n++) begin
                bus_xfer(1'b1, rand_below(2), NE_IRAM_BASE + used_word(32 + rand_below(32)),
                         rand_below(4), $random(seed));
            end
        join

        wait (done_q.size() == 0);
        repeat (2) @(posedge core_clock);
        if (host_resps == host_xfers && inner_resps == inner_xfers) begin
            $display("Simulation PASSED");
            $finish;
        end else if (host_resps != host_xfers) begin
            report_mismatch("host response count", host_xfers, host_resps);
        end else begin
            report_mismatch("inner response count", inner_xfers, inner_resps);
        end
    end

endmodule

`default_nettype wire
